//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_systolic_array
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- operand_feeder.sv
module operand_feeder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_wr_en,
    input  logic [sa_pkg::ADDR_WIDTH-1:0]         i_wr_addr,
    input  sa_pkg::operand_vec_t                  i_top_vec,
    input  sa_pkg::operand_vec_t                  i_left_vec,
    input  logic                                  i_rd_en,
    input  logic [sa_pkg::ADDR_WIDTH-1:0]         i_rd_addr,
    output sa_pkg::lane_t [sa_pkg::NUM_COL-1:0]   o_top_lanes,
    output sa_pkg::lane_t [sa_pkg::NUM_ROW-1:0]   o_left_lanes
);
    import sa_pkg::*;

    operand_vec_t top_mem  [BANK_DEPTH];
    operand_vec_t left_mem [BANK_DEPTH];

    // --------------------------------------------------
    // operand banks
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
        begin
            top_mem[i_wr_addr]  <= i_top_vec;
            left_mem[i_wr_addr] <= i_left_vec;
        end
    end

    // --------------------------------------------------
    // synchronous read plus triangular skew
    // --------------------------------------------------
    // the array is square, so top column k and left row k share one chain
    genvar gk;

    for (gk = 0; gk < NUM_COL; gk++)
    begin : g_skew
        lane_t [1:0] chain [gk+1];               // [0] top lane, [1] left lane

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                for (int s = 0; s <= gk; s++)
                begin
                    chain[s] <= '0;
                end
            end
            else
            begin
                chain[0][0] <= '{valid: i_rd_en, data: top_mem[i_rd_addr][gk]};
                chain[0][1] <= '{valid: i_rd_en, data: left_mem[i_rd_addr][gk]};
                for (int s = 1; s <= gk; s++)
                begin
                    chain[s] <= chain[s-1];      // valid travels with data
                end
            end
        end

        assign o_top_lanes[gk]  = chain[gk][0];  // 1 + gk cycles after address
        assign o_left_lanes[gk] = chain[gk][1];
    end

endmodule

//--- pe_array.sv
module pe_array (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_clear,
    input  logic                                  i_flush,
    input  sa_pkg::lane_t [sa_pkg::NUM_COL-1:0]   i_top_lanes,
    input  sa_pkg::lane_t [sa_pkg::NUM_ROW-1:0]   i_left_lanes,
    output sa_pkg::acc_row_t                      o_bottom_row
);
    import sa_pkg::*;

    lane_t h_lane  [NUM_ROW][NUM_COL+1];   // left to right, column 0 is the edge
    lane_t v_lane  [NUM_ROW+1][NUM_COL];   // top to bottom, row 0 is the edge
    acc_t  acc_col [NUM_ROW+1][NUM_COL];   // flush chain, row 0 feeds zeros

    genvar gr;
    genvar gc;

    // --------------------------------------------------
    // edge wiring
    // --------------------------------------------------
    for (gr = 0; gr < NUM_ROW; gr++)
    begin : g_left_edge
        assign h_lane[gr][0] = i_left_lanes[gr];
    end

    for (gc = 0; gc < NUM_COL; gc++)
    begin : g_top_edge
        assign v_lane[0][gc]            = i_top_lanes[gc];
        assign acc_col[0][gc]           = '0;
        assign o_bottom_row[gc]         = acc_col[NUM_ROW][gc];   // one row per flush cycle
    end

    // --------------------------------------------------
    // PE grid
    // --------------------------------------------------
    for (gr = 0; gr < NUM_ROW; gr++)
    begin : g_row
        for (gc = 0; gc < NUM_COL; gc++)
        begin : g_col
            sa_pe sa_pe_inst (
                .clk      (clk),
                .rst_n    (rst_n),
                .i_clear  (i_clear),
                .i_flush  (i_flush),
                .i_left   (h_lane[gr][gc]),
                .i_top    (v_lane[gr][gc]),
                .i_acc_in (acc_col[gr][gc]),
                .o_right  (h_lane[gr][gc+1]),
                .o_down   (v_lane[gr+1][gc]),
                .o_acc    (acc_col[gr+1][gc])
            );
        end
    end

endmodule

//--- result_bank.sv
module result_bank (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_wr_en,
    input  logic [sa_pkg::ROW_ADDR_WIDTH-1:0]     i_wr_row,
    input  sa_pkg::acc_row_t                      i_wr_data,
    input  logic [sa_pkg::ROW_ADDR_WIDTH-1:0]     i_rd_row,
    output sa_pkg::acc_row_t                      o_rd_data
);
    import sa_pkg::*;

    acc_row_t rows [NUM_ROW];

    always_ff @(posedge clk)
    begin
        if (i_wr_en)
        begin
            rows[i_wr_row] <= i_wr_data;         // filled by the flush
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_rd_data <= '0;
        end
        else
        begin
            o_rd_data <= rows[i_rd_row];         // registered host read
        end
    end

endmodule

//--- sa_controller.sv
module sa_controller (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_req,
    input  sa_pkg::host_req_t                     i_cmd,
    output logic                                  o_ack,
    output logic                                  o_wr_en,
    output logic                                  o_rd_en,
    output logic [sa_pkg::ADDR_WIDTH-1:0]         o_rd_addr,
    output logic                                  o_clear,
    output logic                                  o_flush,
    output logic                                  o_res_wr_en,
    output logic [sa_pkg::ROW_ADDR_WIDTH-1:0]     o_res_wr_row,
    output logic [sa_pkg::ROW_ADDR_WIDTH-1:0]     o_res_rd_row
);
    import sa_pkg::*;

    ctrl_state_e                 state;
    ctrl_state_e                 state_nxt;
    logic [ADDR_WIDTH-1:0]       stream_addr;
    logic [DRAIN_CNT_WIDTH-1:0]  drain_cnt;
    logic [ROW_ADDR_WIDTH-1:0]   flush_row;
    logic                        stream_last;
    logic                        drain_last;

    assign stream_last = ({1'b0, stream_addr} == i_cmd.len - 1'b1);
    assign drain_last  = (drain_cnt == DRAIN_CNT_WIDTH'(DRAIN_CYCLES - 1));

    // --------------------------------------------------
    // command FSM
    // --------------------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (i_req)
                begin
                    case (i_cmd.opcode)
                        OP_LOAD:    state_nxt = ST_LOAD;
                        OP_COMPUTE: state_nxt = ST_STREAM;
                        OP_READ:    state_nxt = ST_READ;
                        default:    state_nxt = ST_ACK;   // unknown opcode, just ack
                    endcase
                end
            end
            ST_LOAD:   state_nxt = ST_ACK;
            ST_STREAM: state_nxt = stream_last ? ST_DRAIN : ST_STREAM;
            ST_DRAIN:  state_nxt = drain_last ? ST_FLUSH : ST_DRAIN;
            ST_FLUSH:  state_nxt = (flush_row == '0) ? ST_ACK : ST_FLUSH;
            ST_READ:   state_nxt = ST_ACK;
            ST_ACK:    state_nxt = i_req ? ST_ACK : ST_IDLE;   // wait for req to drop
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= ST_IDLE;
            stream_addr <= '0;
            drain_cnt   <= '0;
            flush_row   <= '0;
        end
        else
        begin
            state       <= state_nxt;
            stream_addr <= (state == ST_STREAM) ? stream_addr + 1'b1 : '0;
            drain_cnt   <= (state == ST_DRAIN) ? drain_cnt + 1'b1 : '0;
            flush_row   <= (state == ST_FLUSH) ? flush_row - 1'b1
                                               : ROW_ADDR_WIDTH'(NUM_ROW - 1);
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign o_ack        = (state == ST_ACK);
    assign o_wr_en      = (state == ST_LOAD);
    assign o_rd_en      = (state == ST_STREAM);
    assign o_rd_addr    = stream_addr;
    assign o_clear      = (state == ST_STREAM) && (stream_addr == '0);  // first stream cycle
    assign o_flush      = (state == ST_FLUSH);
    assign o_res_wr_en  = (state == ST_FLUSH);
    assign o_res_wr_row = flush_row;                                    // row 3 down to 0
    assign o_res_rd_row = i_cmd.addr[ROW_ADDR_WIDTH-1:0];

endmodule

//--- sa_pe.sv
module sa_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_clear,
    input  logic           i_flush,
    input  sa_pkg::lane_t  i_left,
    input  sa_pkg::lane_t  i_top,
    input  sa_pkg::acc_t   i_acc_in,
    output sa_pkg::lane_t  o_right,
    output sa_pkg::lane_t  o_down,
    output sa_pkg::acc_t   o_acc
);
    import sa_pkg::*;

    acc_t product;

    assign product = acc_t'(i_left.data) * acc_t'(i_top.data);   // zero extended

    // operands move one PE per cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_right <= '0;
            o_down  <= '0;
        end
        else
        begin
            o_right <= i_left;
            o_down  <= i_top;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_acc <= '0;
        end
        else if (i_flush)
        begin
            o_acc <= i_acc_in;                   // shift column downward
        end
        else if (i_clear)
        begin
            o_acc <= '0;
        end
        else if (i_left.valid && i_top.valid)
        begin
            o_acc <= o_acc + product;            // wraps at 32 bits
        end
    end

endmodule

//--- sa_pkg.sv
package sa_pkg;

    // --------------------------------------------------
    // array and bank sizes
    // --------------------------------------------------
    localparam int NUM_ROW         = 4;
    localparam int NUM_COL         = 4;
    localparam int DATA_WIDTH      = 8;                  // unsigned operands
    localparam int ACC_WIDTH       = 32;
    localparam int BANK_DEPTH      = 16;
    localparam int ADDR_WIDTH      = 4;
    localparam int ROW_ADDR_WIDTH  = 2;
    localparam int LEN_WIDTH       = 5;                  // K from 1 to 16

    // bank read, max skew, array crossing, mac register
    localparam int DRAIN_CYCLES    = 1 + (NUM_COL - 1) + (NUM_ROW - 1) + 1;
    localparam int DRAIN_CNT_WIDTH = $clog2(DRAIN_CYCLES);

    // --------------------------------------------------
    // data types
    // --------------------------------------------------
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ACC_WIDTH-1:0]  acc_t;
    typedef data_t [NUM_COL-1:0]   operand_vec_t;        // top or left edge vector
    typedef acc_t  [NUM_COL-1:0]   acc_row_t;            // element c is column c

    typedef struct packed {
        logic  valid;
        data_t data;
    } lane_t;                                            // one skewed edge lane

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_COMPUTE,
        OP_READ
    } opcode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_STREAM,
        ST_DRAIN,
        ST_FLUSH,
        ST_READ,
        ST_ACK
    } ctrl_state_e;

    typedef struct packed {
        opcode_e                 opcode;
        logic [ADDR_WIDTH-1:0]   addr;                   // load address or result row
        logic [LEN_WIDTH-1:0]    len;                    // K for compute
        operand_vec_t            top_vec;
        operand_vec_t            left_vec;
    } host_req_t;

endpackage

//--- sources.f
sa_pkg.sv
sa_pe.sv
pe_array.sv
operand_feeder.sv
result_bank.sv
sa_controller.sv
systolic_array_top.sv
tb_systolic_array.sv

//--- systolic_array_top.sv
module systolic_array_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_req,
    input  sa_pkg::host_req_t   i_cmd,
    output logic                o_ack,
    output sa_pkg::acc_row_t    o_rd_row
);
    import sa_pkg::*;

    logic                        feed_wr_en;
    logic                        feed_rd_en;
    logic [ADDR_WIDTH-1:0]       feed_rd_addr;
    logic                        arr_clear;
    logic                        arr_flush;
    lane_t [NUM_COL-1:0]         top_lanes;
    lane_t [NUM_ROW-1:0]         left_lanes;
    acc_row_t                    bottom_row;
    logic                        res_wr_en;
    logic [ROW_ADDR_WIDTH-1:0]   res_wr_row;
    logic [ROW_ADDR_WIDTH-1:0]   res_rd_row;

    sa_controller sa_controller_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req        (i_req),
        .i_cmd        (i_cmd),
        .o_ack        (o_ack),
        .o_wr_en      (feed_wr_en),
        .o_rd_en      (feed_rd_en),
        .o_rd_addr    (feed_rd_addr),
        .o_clear      (arr_clear),
        .o_flush      (arr_flush),
        .o_res_wr_en  (res_wr_en),
        .o_res_wr_row (res_wr_row),
        .o_res_rd_row (res_rd_row)
    );

    operand_feeder operand_feeder_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wr_en      (feed_wr_en),
        .i_wr_addr    (i_cmd.addr),
        .i_top_vec    (i_cmd.top_vec),
        .i_left_vec   (i_cmd.left_vec),
        .i_rd_en      (feed_rd_en),
        .i_rd_addr    (feed_rd_addr),
        .o_top_lanes  (top_lanes),
        .o_left_lanes (left_lanes)
    );

    pe_array pe_array_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_clear      (arr_clear),
        .i_flush      (arr_flush),
        .i_top_lanes  (top_lanes),
        .i_left_lanes (left_lanes),
        .o_bottom_row (bottom_row)
    );

    result_bank result_bank_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wr_en      (res_wr_en),
        .i_wr_row     (res_wr_row),
        .i_wr_data    (bottom_row),
        .i_rd_row     (res_rd_row),
        .o_rd_data    (o_rd_row)
    );

endmodule

//--- tb_systolic_array.sv
module tb_systolic_array;
    import sa_pkg::*;

    // about 60 commands; loads and reads take ~3 cycles, computes up to ~30
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] SEED  = 32'h8b8f_aca2;

    logic          clk;
    logic          rst_n;
    logic          i_req;
    host_req_t     i_cmd;
    logic          o_ack;
    acc_row_t      o_rd_row;

    operand_vec_t  top_store  [BANK_DEPTH];     // host copy of the banks
    operand_vec_t  left_store [BANK_DEPTH];
    acc_row_t      exp_q [$];
    acc_row_t      act_q [$];
    int            row_q [$];
    logic [31:0]   rng_state;
    int            error_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    int            test_count  = 0;
    int            failed_tests = 0;
    logic          prev_ack = 1'b0;
    logic          prev_req = 1'b0;

    systolic_array_top systolic_array_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_req    (i_req),
        .i_cmd    (i_cmd),
        .o_ack    (o_ack),
        .o_rd_row (o_rd_row)
    );

    always #4 clk = ~clk;

    // --------------------------------------------------
    // stimulus helpers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic operand_vec_t random_vec();
        rng_state = xorshift32(rng_state);
        return operand_vec_t'(rng_state);
    endfunction

    // row r, column c: sum over k of left[k][r] * top[k][c], wraps at 32 bits
    function automatic acc_row_t expected_row(input int row, input int len);
        acc_row_t res;
        res = '0;
        for (int k = 0; k < len; k++)
        begin
            for (int c = 0; c < NUM_COL; c++)
            begin
                res[c] = res[c] + acc_t'(left_store[k][row]) * acc_t'(top_store[k][c]);
            end
        end
        return res;
    endfunction

    // four-phase handshake, called and returning 1 unit after a rising edge
    task automatic send_command(input host_req_t cmd, output acc_row_t rd_row);
        assert (!o_ack)
        else
        begin
            $display("o_ack was still high when a new request started");
            error_count++;
        end
        i_cmd = cmd;
        i_req = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!o_ack);
        rd_row = o_rd_row;                      // valid while ack is high
        i_req  = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (o_ack);
    endtask

    task automatic load_pair(input int addr, input operand_vec_t tv, input operand_vec_t lv);
        host_req_t cmd;
        acc_row_t  unused;
        cmd          = '0;
        cmd.opcode   = OP_LOAD;
        cmd.addr     = ADDR_WIDTH'(addr);
        cmd.top_vec  = tv;
        cmd.left_vec = lv;
        top_store[addr]  = tv;
        left_store[addr] = lv;
        send_command(cmd, unused);
    endtask

    task automatic run_compute(input int len);
        host_req_t cmd;
        acc_row_t  unused;
        cmd        = '0;
        cmd.opcode = OP_COMPUTE;
        cmd.len    = LEN_WIDTH'(len);
        send_command(cmd, unused);
    endtask

    task automatic read_row(input int row, input acc_row_t exp_row);
        host_req_t cmd;
        acc_row_t  got;
        cmd        = '0;
        cmd.opcode = OP_READ;
        cmd.addr   = ADDR_WIDTH'(row);
        send_command(cmd, got);
        exp_q.push_back(exp_row);
        act_q.push_back(got);
        row_q.push_back(row);
    endtask

    task automatic read_all_rows(input int len);
        for (int r = 0; r < NUM_ROW; r++)
        begin
            read_row(r, expected_row(r, len));
        end
    endtask

    // waits until every read row of the test has been compared
    task automatic end_test(input string name, input int errs_before);
        while (act_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
        test_count++;
        if (error_count == errs_before)
        begin
            $display("test %0d %s ok", test_count, name);
        end
        else
        begin
            failed_tests++;
            $display("test %0d %s failed", test_count, name);
        end
    endtask

    // --------------------------------------------------
    // checkers
    // --------------------------------------------------
    always @(negedge clk)
    begin
        acc_row_t exp_row;
        acc_row_t act_row;
        int       row;
        if (act_q.size() > 0)
        begin
            exp_row = exp_q.pop_front();
            act_row = act_q.pop_front();
            row     = row_q.pop_front();
            check_count++;
            assert (act_row === exp_row)
            else
            begin
                $display("Error o_rd_row row %0d: expected %h, got %h", row, exp_row, act_row);
                error_count++;
            end
        end
    end

    // ack may only rise after a request and only fall after it is dropped
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (o_ack && !prev_ack)
            begin
                assert (prev_req)
                else
                begin
                    $display("o_ack rose without a pending i_req");
                    error_count++;
                end
            end
            if (!o_ack && prev_ack)
            begin
                assert (!prev_req)
                else
                begin
                    $display("o_ack fell while i_req was still high");
                    error_count++;
                end
            end
        end
        prev_ack = o_ack;
        prev_req = i_req;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial
    begin
        operand_vec_t tv;
        operand_vec_t lv;
        acc_row_t     exp_row;
        int           errs;
        clk       = 1'b0;
        rst_n     = 1'b0;
        i_req     = 1'b0;
        i_cmd     = '0;
        rng_state = SEED;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs = error_count;
        repeat (10)
        begin
            @(posedge clk);
            #1;
            assert (!o_ack)
            else
            begin
                $display("o_ack went high after reset with no request");
                error_count++;
            end
        end
        end_test("ack low after reset", errs);

        errs = error_count;
        load_pair(0, random_vec(), random_vec());
        repeat (8)
        begin
            @(posedge clk);
            #1;
            assert (!o_ack)
            else
            begin
                $display("a second ack appeared while i_req stayed low");
                error_count++;
            end
        end
        end_test("four-phase handshake", errs);

        errs = error_count;
        for (int i = 0; i < NUM_COL; i++)
        begin
            tv[i] = data_t'(3 * i + 1);
            lv[i] = data_t'(5 * i + 2);
        end
        load_pair(0, tv, lv);
        run_compute(1);
        for (int r = 0; r < NUM_ROW; r++)
        begin
            for (int c = 0; c < NUM_COL; c++)
            begin
                exp_row[c] = acc_t'(lv[r]) * acc_t'(tv[c]);   // outer product
            end
            read_row(r, exp_row);
        end
        end_test("known vectors K=1", errs);

        errs = error_count;
        for (int k = 0; k < BANK_DEPTH; k++)
        begin
            load_pair(k, random_vec(), random_vec());
        end
        run_compute(16);
        read_all_rows(16);
        end_test("random K=16", errs);

        errs = error_count;
        run_compute(5);
        read_all_rows(5);
        run_compute(11);
        read_all_rows(11);
        end_test("back-to-back K=5 then K=11", errs);

        errs = error_count;
        for (int k = 0; k < BANK_DEPTH; k++)
        begin
            load_pair(k, {NUM_COL{8'hFF}}, {NUM_ROW{8'hFF}});
        end
        run_compute(16);
        for (int c = 0; c < NUM_COL; c++)
        begin
            exp_row[c] = 32'd1040400;            // 16 * 255 * 255
        end
        for (int r = 0; r < NUM_ROW; r++)
        begin
            read_row(r, exp_row);
        end
        end_test("max operands K=16", errs);

        $display("%0d tests, %0d failed, %0d rows checked, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
